//--- tb/pitch_align_vectors.txt
// Per test: 16 template samples, 19 search samples (10 then 9 per line),
// then the expected lag and the expected 40-bit sum, all in hex
//
// Test 0: template repeated at lag 2
0000 0000 0000 0000 0100 0000 0000 0000 0200 0000 0000 0000 0100 0000 0000 0000
0000 0000 0000 0000 0000 0000 0100 0000 0000 0000
0200 0000 0000 0000 0100 0000 0000 0000 0000
2 0000050000
// Test 1: template repeated at lag 3, samples outside every window
0000 0000 0000 0000 0400 0000 0000 0000 FE00 0000 0000 0000 0200 0000 0000 0000
1234 0000 0000 0000 0000 0000 0000 0400 0000 0000
0000 FE00 0000 0000 0000 0200 0000 0000 7FFF
3 00000E0000
// Test 2: all-zero search region
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000
0 0000000000
// Test 3: negated template, every sum negative
0000 0000 0000 0000 FF00 0000 0000 0000 FE00 0000 0000 0000 FF00 0000 0000 0000
0001 0001 0001 0001 0002 0002 0002 0002 0004 0003
0001 0002 0002 0002 0002 0002 0001 0001 0001
2 FFFFFFFC00
// Test 4: lags 1 and 3 tie
0000 0000 0000 0000 0000 0000 0000 0000 0100 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0010
0000 0010 0000 0000 0000 0000 0000 0000 0000
1 0000001000
// Test 5: flat template, two impulses in the search
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0000 0000 0100 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0100 0000 0000 0000 0000 0000
3 000000DA00
// Test 6: full-scale samples
0000 0000 0000 0000 8000 0000 0000 0000 7FFF 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 8000 7FFF 0000
0000 7FFF 0000 0000 0000 0000 0000 0000 0000
3 005FFF0001

//--- vlog.f
+incdir+verilog
verilog/pitch_pkg.sv
verilog/frame_feeder.sv
verilog/lag_correlator.sv
verilog/peak_picker.sv
verilog/pitch_align_top.sv
tb/pitch_align_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pitch_align_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/pitch_align_tb.sv
// ======================================================================
// Pitch alignment testbench
// Directed vectors from a data file, random frames, gapped and
// back-to-back searches, each checked against a reference model for
// lag, peak sum and done latency
// ======================================================================
`timescale 1ns/100ps
`include "pitch_macros.svh"

module pitch_align_tb
    import pitch_pkg::*;
();

    localparam int WIN       = `PITCH_WIN;
    localparam int LAGS      = `PITCH_LAGS;
    localparam int SLEN      = `PITCH_WIN + `PITCH_LAGS - 1;
    localparam int NUM_VEC   = 7;
    localparam int REC_LEN   = WIN + SLEN + 2;   // Template, search, lag, sum
    localparam int NUM_RAND  = 50;
    localparam int NUM_TESTS = 1 + NUM_VEC + 2 + 2 + NUM_RAND;
    localparam int WATCHDOG  = NUM_TESTS * (WIN + SLEN + 10);
    localparam int DONE_WAIT = SLEN + 10;
    localparam int LATENCY   = 3;

    logic      i_clk;
    logic      i_rst;
    logic      frame_load;
    sample_t   frame_sample;
    logic      search_valid;
    sample_t   search_sample;
    lag_t      best_lag;
    corr_sum_t best_sum;
    logic      done;

    logic [`PITCH_SUM_W-1:0] vec_mem [NUM_VEC*REC_LEN];
    sample_t tmpl [WIN];
    sample_t srch [SLEN];
    int      cycle_cnt = 0;
    int      err_cnt   = 0;
    int      fail_cnt  = 0;
    int      test_cnt  = 0;

    int      exp_lag [$];
    longint  exp_sum [$];
    int      exp_cycle [$];
    int      got_lag [$];
    longint  got_sum [$];
    int      got_cycle [$];

    pitch_align_top dut_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .frame_load    (frame_load),
        .frame_sample  (frame_sample),
        .search_valid  (search_valid),
        .search_sample (search_sample),
        .best_lag      (best_lag),
        .best_sum      (best_sum),
        .done          (done)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Results sampled mid-cycle, tagged with the edge count
    always @(negedge i_clk) begin
        if (done === 1'b1) begin
            got_lag.push_back(int'(best_lag));
            got_sum.push_back(longint'(best_sum));
            got_cycle.push_back(cycle_cnt);
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge i_clk);
        $display("Run timed out after %0d cycles", WATCHDOG);
        $display("Checks failed");
        $finish;
    end

    task automatic drive_idle();
        @(posedge i_clk);
        #2;
        frame_load   = 1'b0;
        search_valid = 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < WIN; i++) begin
            tmpl[i] = sample_t'($urandom);
        end
        for (int j = 0; j < SLEN; j++) begin
            srch[j] = sample_t'($urandom);
        end
    endtask

    task automatic load_template();
        for (int i = 0; i < WIN; i++) begin
            @(posedge i_clk);
            #2;
            search_valid = 1'b0;
            frame_load   = 1'b1;
            frame_sample = tmpl[i];
        end
    endtask

    task automatic run_search(input int max_gap);
        int gap;
        for (int j = 0; j < SLEN; j++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                @(posedge i_clk);
                #2;
                frame_load   = 1'b0;
                search_valid = 1'b0;
            end
            @(posedge i_clk);
            #2;
            frame_load    = 1'b0;
            search_valid  = 1'b1;
            search_sample = srch[j];
        end
        exp_cycle.push_back(cycle_cnt + 1);   // Taken on the coming edge
    endtask

    // Hann-weighted template against each lag, strict max, low lag wins ties
    task automatic predict();
        longint w [WIN];
        longint sum;
        longint best;
        int     lag;
        best = longint'(64'h8000_0000_0000_0000);
        lag  = 0;
        for (int i = 0; i < WIN; i++) begin
            w[i] = (longint'(tmpl[i]) * longint'(HANN_COEF[i])) >>> `PITCH_COEF_SHIFT;
        end
        for (int l = 0; l < LAGS; l++) begin
            sum = 0;
            for (int i = 0; i < WIN; i++) begin
                sum += longint'(srch[l + i]) * w[i];
            end
            if (sum > best) begin
                best = sum;
                lag  = l;
            end
        end
        exp_lag.push_back(lag);
        exp_sum.push_back(best);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic check_results(input string name, input int n);
        int     waited;
        int     errs_before;
        int     lag_e;
        int     lag_g;
        longint sum_e;
        longint sum_g;
        int     lat;
        errs_before = err_cnt;
        waited      = 0;
        while (got_lag.size() < n && waited < DONE_WAIT * n) begin
            @(posedge i_clk);
            waited++;
        end
        repeat (2) @(posedge i_clk);   // Catch any stray extra pulse
        assert (got_lag.size() == n) else begin
            $display("%s: %0d done pulses seen where %0d were due", name, got_lag.size(), n);
            err_cnt++;
        end
        while (got_lag.size() > 0 && exp_lag.size() > 0) begin
            lag_e = exp_lag.pop_front();
            lag_g = got_lag.pop_front();
            sum_e = exp_sum.pop_front();
            sum_g = got_sum.pop_front();
            lat   = got_cycle.pop_front() - exp_cycle.pop_front();
            assert (lag_g == lag_e) else begin
                $display("MISMATCH %s best_lag expected %0d actual %0d", name, lag_e, lag_g);
                err_cnt++;
            end
            assert (sum_g == sum_e) else begin
                $display("MISMATCH %s best_sum expected %0d actual %0d", name, sum_e, sum_g);
                err_cnt++;
            end
            assert (lat == LATENCY) else begin
                $display("MISMATCH %s done latency expected %0d actual %0d", name, LATENCY, lat);
                err_cnt++;
            end
        end
        exp_lag.delete();
        exp_sum.delete();
        exp_cycle.delete();
        got_lag.delete();
        got_sum.delete();
        got_cycle.delete();
        report_test(name, errs_before);
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = err_cnt;
        @(negedge i_clk);
        assert (done === 1'b0) else begin
            $display("MISMATCH reset_state done expected 0 actual %b", done);
            err_cnt++;
        end
        assert (best_lag === '0) else begin
            $display("MISMATCH reset_state best_lag expected 0 actual %0d", best_lag);
            err_cnt++;
        end
        assert (best_sum === '0) else begin
            $display("MISMATCH reset_state best_sum expected 0 actual %0d", best_sum);
            err_cnt++;
        end
        fill_random();
        load_template();
        drive_idle();
        repeat (4) @(posedge i_clk);
        assert (got_lag.size() == 0) else begin
            $display("reset_state: done pulsed while only a template was loaded");
            err_cnt++;
        end
        got_lag.delete();
        got_sum.delete();
        got_cycle.delete();
        report_test("reset_state", errs_before);
    endtask

    initial begin
        int base;
        i_rst         = 1'b1;
        frame_load    = 1'b0;
        frame_sample  = '0;
        search_valid  = 1'b0;
        search_sample = '0;
        void'($urandom(32'h15ab7000));
        $readmemh("tb/pitch_align_vectors.txt", vec_mem);
        repeat (5) @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        test_reset();

        for (int v = 0; v < NUM_VEC; v++) begin
            base = v * REC_LEN;
            for (int i = 0; i < WIN; i++) begin
                tmpl[i] = sample_t'(vec_mem[base + i]);
            end
            for (int j = 0; j < SLEN; j++) begin
                srch[j] = sample_t'(vec_mem[base + WIN + j]);
            end
            exp_lag.push_back(int'(vec_mem[base + WIN + SLEN]));
            exp_sum.push_back(longint'(corr_sum_t'(vec_mem[base + WIN + SLEN + 1])));
            load_template();
            run_search(0);
            drive_idle();
            check_results($sformatf("vector_%0d", v), 1);
        end

        for (int k = 0; k < 2; k++) begin
            fill_random();
            predict();
            load_template();
            run_search(2);   // Random idle cycles between samples
            drive_idle();
            check_results($sformatf("gap_timing_%0d", k), 1);
        end

        // Second search follows the first with no idle cycle
        fill_random();
        predict();
        load_template();
        run_search(0);
        for (int j = 0; j < SLEN; j++) begin
            srch[j] = sample_t'($urandom);
        end
        predict();
        run_search(0);
        drive_idle();
        check_results("back_to_back", 2);

        for (int r = 0; r < NUM_RAND; r++) begin
            fill_random();
            predict();
            load_template();
            run_search(0);
            drive_idle();
            check_results($sformatf("random_%0d", r), 1);
        end

        $display("Tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog/pitch_align_top.sv
// ======================================================================
// Pitch alignment top level
// Template feeder, one correlator lane per lag and the peak picker
// Result follows the last search sample by three cycles
// ======================================================================
`timescale 1ns/100ps
`include "pitch_macros.svh"

module pitch_align_top
    import pitch_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      frame_load,
    input  sample_t   frame_sample,
    input  logic      search_valid,
    input  sample_t   search_sample,
    output lag_t      best_lag,
    output corr_sum_t best_sum,
    output logic      done
);

    bcast_t    bcast;
    sample_t   template [`PITCH_WIN];
    logic      search_last;
    corr_sum_t lane_sum [`PITCH_LAGS];

    frame_feeder feeder_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .frame_load    (frame_load),
        .frame_sample  (frame_sample),
        .search_valid  (search_valid),
        .search_sample (search_sample),
        .bcast         (bcast),
        .template      (template),
        .search_last   (search_last)
    );

    genvar g;
    generate
        for (g = 0; g < `PITCH_LAGS; g++) begin : g_lane
            lag_correlator #(.LAG(g)) lane_i (
                .i_clk    (i_clk),
                .i_rst    (i_rst),
                .bcast    (bcast),
                .template (template),
                .lane_sum (lane_sum[g])
            );
        end
    endgenerate

    peak_picker picker_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .search_last (search_last),
        .lane_sum    (lane_sum),
        .best_lag    (best_lag),
        .best_sum    (best_sum),
        .done        (done)
    );

endmodule

//--- verilog/peak_picker.sv
// ======================================================================
// Peak picker
// Snapshots every lane sum once a search completes and registers the
// lag of the strict maximum, lowest lag first on a tie
// ======================================================================
`timescale 1ns/100ps
`include "pitch_macros.svh"

module peak_picker
    import pitch_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      search_last,
    input  corr_sum_t lane_sum [`PITCH_LAGS],
    output lag_t      best_lag,
    output corr_sum_t best_sum,
    output logic      done
);

    localparam corr_sum_t SUM_MIN = {1'b1, {(`PITCH_SUM_W-1){1'b0}}};

    logic      last_d;      // Lanes finish one cycle after the last broadcast
    logic      cap_valid;
    corr_sum_t snap [`PITCH_LAGS];
    corr_sum_t sel_sum;
    lag_t      sel_lag;

    always_comb begin
        sel_sum = SUM_MIN;
        sel_lag = '0;
        for (int i = 0; i < `PITCH_LAGS; i++) begin
            if (snap[i] > sel_sum) begin   // Strict, so ties keep the lower lag
                sel_sum = snap[i];
                sel_lag = lag_t'(i);
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            last_d    <= 1'b0;
            cap_valid <= 1'b0;
            done      <= 1'b0;
            best_lag  <= '0;
            best_sum  <= '0;
        end else begin
            last_d    <= search_last;
            cap_valid <= last_d;
            done      <= cap_valid;
            if (cap_valid) begin
                best_lag <= sel_lag;
                best_sum <= sel_sum;
            end
        end
    end

    // Frees the lanes for the next search right away
    always_ff @(posedge i_clk) begin
        if (last_d) begin
            for (int i = 0; i < `PITCH_LAGS; i++) begin
                snap[i] <= lane_sum[i];
            end
        end
    end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

//--- verilog/lag_correlator.sv
// ======================================================================
// Lag correlator lane
// Accumulates the cross-correlation of the windowed template with the
// search region at one fixed lag
// ======================================================================
`timescale 1ns/100ps
`include "pitch_macros.svh"

module lag_correlator
    import pitch_pkg::*;
#(
    parameter int LAG = 0
) (
    input  logic      i_clk,
    input  logic      i_rst,
    input  bcast_t    bcast,
    input  sample_t   template [`PITCH_WIN],
    output corr_sum_t lane_sum
);

    localparam pos_t FIRST_POS  = pos_t'(LAG);
    localparam pos_t WIN_END    = pos_t'(LAG + `PITCH_WIN - 1);
    localparam pos_t SEARCH_END = pos_t'(`PITCH_WIN + `PITCH_LAGS - 2);

    logic      in_window;
    tap_t      tap;
    prod_t     product;
    corr_sum_t term;

    assign in_window = (bcast.pos >= FIRST_POS) && (bcast.pos <= WIN_END);
    assign tap       = tap_t'(bcast.pos - FIRST_POS);
    assign product   = prod_t'(bcast.sample) * prod_t'(template[tap]);
    assign term      = in_window ? corr_sum_t'(product) : '0;

    always_ff @(posedge i_clk) begin
        if (bcast.valid) begin
            if (bcast.pos == '0) begin
                lane_sum <= term;   // First sample of a search
            end else if (in_window) begin
                lane_sum <= lane_sum + term;
            end
        end
    end

    // Feeder positions stay inside the search region
    a_pos_range: assert property (@(posedge i_clk) disable iff (i_rst)
        bcast.valid |-> (bcast.pos <= SEARCH_END))
        else $error("lane %0d saw position %0d", LAG, bcast.pos);

endmodule

//--- verilog/frame_feeder.sv
// ======================================================================
// Frame feeder
// Stores the Hann-windowed template as it is loaded, then numbers each
// search sample and broadcasts it to all correlator lanes
// ======================================================================
`timescale 1ns/100ps
`include "pitch_macros.svh"

module frame_feeder
    import pitch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    frame_load,
    input  sample_t frame_sample,
    input  logic    search_valid,
    input  sample_t search_sample,
    output bcast_t  bcast,
    output sample_t template [`PITCH_WIN],
    output logic    search_last
);

    localparam tap_t LAST_TAP = tap_t'(`PITCH_WIN - 1);
    localparam pos_t LAST_POS = pos_t'(`PITCH_WIN + `PITCH_LAGS - 2);

    feed_state_t state;
    tap_t        tap_cnt;
    pos_t        pos_cnt;
    prod_t       win_prod;
    prod_t       win_shift;
    logic        search_ok;
    logic        last_pos;

    // Template sample times its window coefficient, back to Q15
    assign win_prod  = prod_t'(frame_sample) * prod_t'(HANN_COEF[tap_cnt]);
    assign win_shift = win_prod >>> `PITCH_COEF_SHIFT;

    assign search_ok = search_valid && (state == FEED_SEARCH);
    assign last_pos  = (pos_cnt == LAST_POS);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state       <= FEED_IDLE;
            tap_cnt     <= '0;
            pos_cnt     <= '0;
            bcast       <= '0;
            search_last <= 1'b0;
        end else begin
            bcast.valid <= search_ok;
            search_last <= search_ok && last_pos;
            if (search_ok) begin
                bcast.pos    <= pos_cnt;
                bcast.sample <= search_sample;
                pos_cnt      <= last_pos ? '0 : pos_cnt + 1'b1;
            end

            if (frame_load) begin
                tap_cnt <= (tap_cnt == LAST_TAP) ? '0 : tap_cnt + 1'b1;
                pos_cnt <= '0;   // New template abandons any partial search
            end

            case (state)
                FEED_IDLE: begin
                    if (frame_load) begin
                        state <= FEED_LOAD;
                    end
                end
                FEED_LOAD: begin
                    if (frame_load && tap_cnt == LAST_TAP) begin
                        state <= FEED_SEARCH;
                    end
                end
                FEED_SEARCH: begin
                    // Template stays in use until a new one starts
                    if (frame_load) begin
                        state <= FEED_LOAD;
                    end
                end
                default: begin
                    state <= FEED_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (frame_load) begin
            template[tap_cnt] <= sample_t'(win_shift);
        end
    end

    // Caller keeps the two strobes apart
    a_no_overlap: assert property (@(posedge i_clk) disable iff (i_rst)
        !(frame_load && search_valid))
        else $error("frame_load and search_valid high together");

    // Search must wait for the whole template
    a_no_early_search: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == FEED_LOAD) |-> !search_valid)
        else $error("search sample during template load");

endmodule

//--- verilog/pitch_pkg.sv
// ======================================================================
// Pitch alignment types
// Sample and sum types, the lane broadcast word, the feeder states and
// the periodic Hann window in Q1.15
// ======================================================================
`include "pitch_macros.svh"

package pitch_pkg;

    typedef logic signed [`PITCH_SAMPLE_W-1:0] sample_t;
    typedef logic        [`PITCH_COEF_W-1:0]   coef_t;
    typedef logic signed [`PITCH_PROD_W-1:0]   prod_t;
    typedef logic signed [`PITCH_SUM_W-1:0]    corr_sum_t;
    typedef logic        [`PITCH_LAG_W-1:0]    lag_t;
    typedef logic        [`PITCH_POS_W-1:0]    pos_t;
    typedef logic        [`PITCH_TAP_W-1:0]    tap_t;

    // One search sample as seen by every lane
    typedef struct packed {
        logic    valid;
        pos_t    pos;
        sample_t sample;
    } bcast_t;

    // 0.5 * (1 - cos(2*pi*n/16)), scaled by 32768
    localparam coef_t HANN_COEF [`PITCH_WIN] = '{
        16'd0,     16'd1247,  16'd4799,  16'd10114,
        16'd16384, 16'd22654, 16'd27969, 16'd31521,
        16'd32768, 16'd31521, 16'd27969, 16'd22654,
        16'd16384, 16'd10114, 16'd4799,  16'd1247
    };

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_LOAD,
        FEED_SEARCH
    } feed_state_t;

endpackage

//--- verilog/pitch_macros.svh
// ======================================================================
// Pitch alignment parameters
// Window length, lag count, Hann shift and datapath widths shared by
// the similarity search blocks
// ======================================================================
`ifndef PITCH_MACROS_SVH
`define PITCH_MACROS_SVH

`define PITCH_WIN         16   // Template length in samples
`define PITCH_LAGS        4    // Lags searched, one lane each
`define PITCH_COEF_SHIFT  15   // Q1.15 Hann coefficients

`define PITCH_SAMPLE_W    16
`define PITCH_COEF_W      16
`define PITCH_PROD_W      32
`define PITCH_SUM_W       40

// Index widths
`define PITCH_LAG_W       2    // Covers PITCH_LAGS
`define PITCH_POS_W       5    // Covers PITCH_WIN + PITCH_LAGS - 1
`define PITCH_TAP_W       4    // Covers PITCH_WIN

`endif
